/* dcache_consts.svh */
`ifndef DCACHE_CONSTS_SVH
`define DCACHE_CONSTS_SVH

`default_nettype none

// Physical address width in bits
`define DC_PADDR_W 16

// One doubleword per line
`define DC_DWORD_W 64

// Direct mapped line count
`define DC_SETS 16

// Replay FIFO entries, power of two
`define DC_FIFO_DEPTH 8

`default_nettype wire

`endif

/* dcache_pkg.sv */
`include "dcache_consts.svh"
`default_nettype none

package dcache_pkg;

  typedef logic [`DC_PADDR_W-1:0] paddr_t;
  typedef logic [`DC_DWORD_W-1:0] dword_t;
  typedef logic [$clog2(`DC_SETS)-1:0] dc_index_t;
  typedef logic [`DC_PADDR_W-$clog2(`DC_SETS)-$clog2(`DC_DWORD_W/8)-1:0] dc_tag_t;

  // Extra wrap bit above the slot bits
  typedef logic [$clog2(`DC_FIFO_DEPTH):0] fifo_ptr_t;

  typedef enum logic {e_dcache_ld, e_dcache_sd} dcache_op_e;
  typedef enum logic {e_mem_rd, e_mem_wr} mem_op_e;
  typedef enum logic [1:0] {e_idle, e_send, e_wait_rev} me_state_e;

  typedef struct packed {
    dcache_op_e op;
    paddr_t     paddr;
    dword_t     data;
  } dcache_pkt_s;

  // Same layout in both directions
  typedef struct packed {
    mem_op_e op;
    paddr_t  paddr;
  } mem_hdr_s;

  typedef struct packed {
    logic        v;
    dcache_pkt_s pkt;
  } miss_req_s;

  typedef struct packed {
    logic      v;
    dc_index_t index;
    dc_tag_t   tag;
    dword_t    data;
  } fill_s;

  function automatic dc_index_t dc_index(paddr_t paddr);
    return paddr[$clog2(`DC_DWORD_W/8) +: $bits(dc_index_t)];
  endfunction

  function automatic dc_tag_t dc_tag(paddr_t paddr);
    return paddr[`DC_PADDR_W-1 -: $bits(dc_tag_t)];
  endfunction

endpackage

`default_nettype wire

/* replay_fifo.sv */
`timescale 1ns/1ps
`include "dcache_consts.svh"
`default_nettype none

module replay_fifo
  ( input  wire                          clk_i
  , input  wire                          rst_n_i

  , input  wire dcache_pkg::dcache_pkt_s pkt_i
  , input  wire                          v_i
  , output logic                         ready_o

  , output dcache_pkg::dcache_pkt_s      pkt_o
  , output logic                         v_o
  , input  wire                          yumi_i

  , input  wire                          retire_i
  , input  wire                          roll_i
  );

  localparam int PtrW = $clog2(`DC_FIFO_DEPTH);

  dcache_pkg::dcache_pkt_s mem_q [`DC_FIFO_DEPTH];

  dcache_pkg::fifo_ptr_t wr_ptr_q;
  dcache_pkg::fifo_ptr_t rd_ptr_q;
  dcache_pkg::fifo_ptr_t ret_ptr_q;

  logic full;
  logic enq;

  // Space is only freed once an entry retires, not when it is read
  assign full = (wr_ptr_q[PtrW] != ret_ptr_q[PtrW])
             && (wr_ptr_q[PtrW-1:0] == ret_ptr_q[PtrW-1:0]);

  assign ready_o = ~full;
  assign enq     = v_i & ~full;

  // Entries between read and write pointers are still to be issued
  assign v_o   = (rd_ptr_q != wr_ptr_q);
  assign pkt_o = mem_q[rd_ptr_q[PtrW-1:0]];

  always_ff @(posedge clk_i)
  begin
    if (enq)
      mem_q[wr_ptr_q[PtrW-1:0]] <= pkt_i;
  end

  always_ff @(posedge clk_i)
  begin
    if (!rst_n_i)
    begin
      wr_ptr_q  <= '0;
      rd_ptr_q  <= '0;
      ret_ptr_q <= '0;
    end
    else
    begin
      if (enq)
        wr_ptr_q <= wr_ptr_q + 1'b1;

      if (retire_i)
        ret_ptr_q <= ret_ptr_q + 1'b1;

      // Rewind so the oldest unretired entry issues again
      if (roll_i)
        rd_ptr_q <= ret_ptr_q;
      else if (yumi_i)
        rd_ptr_q <= rd_ptr_q + 1'b1;
    end
  end

endmodule

`default_nettype wire

/* dcache_pipe.sv */
`timescale 1ns/1ps
`include "dcache_consts.svh"
`default_nettype none

module dcache_pipe
  ( input  wire                          clk_i
  , input  wire                          rst_n_i

  , input  wire dcache_pkg::dcache_pkt_s pkt_i
  , input  wire                          v_i
  , output logic                         ready_o
  , output logic                         yumi_o

  , output logic                         retire_o
  , output logic                         roll_o

  , output dcache_pkg::dword_t           data_o
  , output logic                         v_o

  , output dcache_pkg::miss_req_s        miss_req_o
  , input  wire                          busy_i
  , input  wire dcache_pkg::fill_s       fill_i
  );

  logic [`DC_SETS-1:0] valid_q;
  dcache_pkg::dc_tag_t tag_mem [`DC_SETS];
  dcache_pkg::dword_t  data_mem [`DC_SETS];

  logic                    s1_v_q;
  dcache_pkg::dcache_pkt_s s1_pkt_q;
  dcache_pkg::dc_index_t   s1_index;

  logic                    s2_v_q;
  dcache_pkg::dcache_pkt_s s2_pkt_q;
  logic                    s2_line_v_q;
  dcache_pkg::dc_tag_t     s2_tag_q;
  dcache_pkg::dword_t      s2_data_q;
  dcache_pkg::dc_index_t   s2_index;

  logic s2_is_ld;
  logic s2_hit;
  logic engine_free;
  logic ld_done;
  logic st_done;
  logic done;

  logic                  fill_we;
  logic                  st_we;
  logic                  wr_en;
  logic                  bypass;
  dcache_pkg::dc_index_t wr_index;
  dcache_pkg::dword_t    wr_data;

  assign s1_index = dcache_pkg::dc_index(s1_pkt_q.paddr);
  assign s2_index = dcache_pkg::dc_index(s2_pkt_q.paddr);

  assign s2_is_ld = (s2_pkt_q.op == dcache_pkg::e_dcache_ld);
  assign s2_hit   = s2_line_v_q && (s2_tag_q == dcache_pkg::dc_tag(s2_pkt_q.paddr));

  // The fill cycle has busy low but still owns the array write port
  assign engine_free = ~busy_i & ~fill_i.v;

  assign ld_done = s2_v_q & s2_is_ld & s2_hit;
  assign st_done = s2_v_q & ~s2_is_ld & engine_free;
  assign done    = ld_done | st_done;

  assign v_o      = done;
  assign retire_o = done;
  assign roll_o   = s2_v_q & ~done;
  assign data_o   = s2_is_ld ? s2_data_q : s2_pkt_q.data;

  assign ready_o = ~busy_i;
  assign yumi_o  = v_i & ready_o & ~roll_o;

  // Stores always write through, loads ask only on a miss
  assign miss_req_o.v   = s2_v_q & engine_free & (~s2_is_ld | ~s2_hit);
  assign miss_req_o.pkt = s2_pkt_q;

  assign fill_we  = fill_i.v;
  assign st_we    = st_done & s2_hit;
  assign wr_en    = fill_we | st_we;
  assign wr_index = fill_we ? fill_i.index : s2_index;
  assign wr_data  = fill_we ? fill_i.data : s2_pkt_q.data;
  assign bypass   = wr_en && (wr_index == s1_index);

  always_ff @(posedge clk_i)
  begin
    if (!rst_n_i)
    begin
      s1_v_q  <= 1'b0;
      s2_v_q  <= 1'b0;
      valid_q <= '0;
    end
    else
    begin
      s1_v_q <= yumi_o;
      s2_v_q <= s1_v_q & ~roll_o;
      if (fill_we)
        valid_q[wr_index] <= 1'b1;
    end
  end

  always_ff @(posedge clk_i)
  begin
    if (yumi_o)
      s1_pkt_q <= pkt_i;
    s2_pkt_q <= s1_pkt_q;

    // Forward a same-cycle write so stage 2 never sees a stale line
    if (bypass && fill_we)
    begin
      s2_line_v_q <= 1'b1;
      s2_tag_q    <= fill_i.tag;
    end
    else
    begin
      s2_line_v_q <= valid_q[s1_index];
      s2_tag_q    <= tag_mem[s1_index];
    end
    s2_data_q <= bypass ? wr_data : data_mem[s1_index];
  end

  always_ff @(posedge clk_i)
  begin
    if (wr_en)
      data_mem[wr_index] <= wr_data;
    if (fill_we)
      tag_mem[wr_index] <= fill_i.tag;
  end

endmodule

`default_nettype wire

/* miss_engine.sv */
`timescale 1ns/1ps
`default_nettype none

module miss_engine
  ( input  wire                        clk_i
  , input  wire                        rst_n_i

  , input  wire dcache_pkg::miss_req_s miss_req_i
  , output logic                       busy_o
  , output dcache_pkg::fill_s          fill_o

  , output dcache_pkg::mem_hdr_s       mem_fwd_o
  , output dcache_pkg::dword_t         mem_fwd_data_o
  , output logic                       mem_fwd_v_o
  , input  wire                        mem_fwd_ready_and_i

  , input  wire dcache_pkg::mem_hdr_s  mem_rev_i
  , input  wire dcache_pkg::dword_t    mem_rev_data_i
  , input  wire                        mem_rev_v_i
  , output logic                       mem_rev_ready_and_o
  );

  dcache_pkg::me_state_e   state_q;
  dcache_pkg::me_state_e   state_d;
  dcache_pkg::dcache_pkt_s req_q;

  logic                 fill_v_q;
  dcache_pkg::mem_hdr_s fill_hdr_q;
  dcache_pkg::dword_t   fill_data_q;

  logic take_req;
  logic rev_done;

  assign take_req = (state_q == dcache_pkg::e_idle) & miss_req_i.v;
  assign rev_done = (state_q == dcache_pkg::e_wait_rev) & mem_rev_v_i & mem_rev_ready_and_o;

  always_comb
  begin
    state_d = state_q;
    unique case (state_q)
      dcache_pkg::e_idle:
        if (miss_req_i.v)
          state_d = dcache_pkg::e_send;
      dcache_pkg::e_send:
        if (mem_fwd_ready_and_i)
          state_d = dcache_pkg::e_wait_rev;
      dcache_pkg::e_wait_rev:
        if (mem_rev_v_i)
          state_d = dcache_pkg::e_idle;
      default:
        state_d = dcache_pkg::e_idle;
    endcase
  end

  always_ff @(posedge clk_i)
  begin
    if (!rst_n_i)
    begin
      state_q  <= dcache_pkg::e_idle;
      fill_v_q <= 1'b0;
    end
    else
    begin
      state_q  <= state_d;
      // Write acks carry nothing for the arrays
      fill_v_q <= rev_done & (mem_rev_i.op == dcache_pkg::e_mem_rd);
    end
  end

  always_ff @(posedge clk_i)
  begin
    if (take_req)
      req_q <= miss_req_i.pkt;
    if (rev_done)
    begin
      fill_hdr_q  <= mem_rev_i;
      fill_data_q <= mem_rev_data_i;
    end
  end

  assign busy_o = (state_q != dcache_pkg::e_idle);

  assign mem_fwd_v_o     = (state_q == dcache_pkg::e_send);
  assign mem_fwd_o.op    = (req_q.op == dcache_pkg::e_dcache_sd) ? dcache_pkg::e_mem_wr
                                                                 : dcache_pkg::e_mem_rd;
  assign mem_fwd_o.paddr = req_q.paddr;
  assign mem_fwd_data_o  = req_q.data;

  // A reply cannot precede its request
  assign mem_rev_ready_and_o = (state_q != dcache_pkg::e_send);

  assign fill_o.v     = fill_v_q;
  assign fill_o.index = dcache_pkg::dc_index(fill_hdr_q.paddr);
  assign fill_o.tag   = dcache_pkg::dc_tag(fill_hdr_q.paddr);
  assign fill_o.data  = fill_data_q;

endmodule

`default_nettype wire

/* dcache_top.sv */
`timescale 1ns/1ps
`default_nettype none

module dcache_top
  ( input  wire                          clk_i
  , input  wire                          rst_n_i

  , input  wire dcache_pkg::dcache_pkt_s dcache_pkt_i
  , input  wire                          v_i
  , output logic                         ready_o

  , output dcache_pkg::dword_t           data_o
  , output logic                         v_o

  , output dcache_pkg::mem_hdr_s         mem_fwd_o
  , output dcache_pkg::dword_t           mem_fwd_data_o
  , output logic                         mem_fwd_v_o
  , input  wire                          mem_fwd_ready_and_i

  , input  wire dcache_pkg::mem_hdr_s    mem_rev_i
  , input  wire dcache_pkg::dword_t      mem_rev_data_i
  , input  wire                          mem_rev_v_i
  , output logic                         mem_rev_ready_and_o
  );

  dcache_pkg::dcache_pkt_s rolly_pkt;
  logic                    rolly_v;
  logic                    rolly_yumi;
  logic                    retire;
  logic                    rollback;

  dcache_pkg::miss_req_s   miss_req;
  logic                    miss_busy;
  dcache_pkg::fill_s       fill;

  replay_fifo rolly
    ( .clk_i    (clk_i)
    , .rst_n_i  (rst_n_i)
    , .pkt_i    (dcache_pkt_i)
    , .v_i      (v_i)
    , .ready_o  (ready_o)
    , .pkt_o    (rolly_pkt)
    , .v_o      (rolly_v)
    , .yumi_i   (rolly_yumi)
    , .retire_i (retire)
    , .roll_i   (rollback)
    );

  // Readiness is already folded into yumi
  dcache_pipe dcache
    ( .clk_i      (clk_i)
    , .rst_n_i    (rst_n_i)
    , .pkt_i      (rolly_pkt)
    , .v_i        (rolly_v)
    , .ready_o    ()
    , .yumi_o     (rolly_yumi)
    , .retire_o   (retire)
    , .roll_o     (rollback)
    , .data_o     (data_o)
    , .v_o        (v_o)
    , .miss_req_o (miss_req)
    , .busy_i     (miss_busy)
    , .fill_i     (fill)
    );

  miss_engine uce
    ( .clk_i               (clk_i)
    , .rst_n_i             (rst_n_i)
    , .miss_req_i          (miss_req)
    , .busy_o              (miss_busy)
    , .fill_o              (fill)
    , .mem_fwd_o           (mem_fwd_o)
    , .mem_fwd_data_o      (mem_fwd_data_o)
    , .mem_fwd_v_o         (mem_fwd_v_o)
    , .mem_fwd_ready_and_i (mem_fwd_ready_and_i)
    , .mem_rev_i           (mem_rev_i)
    , .mem_rev_data_i      (mem_rev_data_i)
    , .mem_rev_v_i         (mem_rev_v_i)
    , .mem_rev_ready_and_o (mem_rev_ready_and_o)
    );

endmodule

`default_nettype wire

/* dcache_checker.sv */
`timescale 1ns/1ps
`default_nettype none

module dcache_checker
  ( input wire                       clk_i
  , input wire                       rst_n_i
  , input wire                       v_o
  , input wire dcache_pkg::dword_t   data_o
  , input wire dcache_pkg::mem_hdr_s mem_fwd_o
  , input wire dcache_pkg::dword_t   mem_fwd_data_o
  , input wire                       mem_fwd_v_o
  , input wire                       mem_fwd_ready_and_i
  );

  // Count of assertion failures so far
  int unsigned err_cnt = 0;

  // Forward beat held until memory takes it
  fwd_stable: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    mem_fwd_v_o && !mem_fwd_ready_and_i |=>
      mem_fwd_v_o && $stable(mem_fwd_o) && $stable(mem_fwd_data_o))
    else
    begin
      $error("forward beat changed before it was taken");
      err_cnt++;
    end

  quiet_after_reset: assert property (@(posedge clk_i)
    $rose(rst_n_i) |-> !v_o && !mem_fwd_v_o)
    else
    begin
      $error("valid output high right after reset");
      err_cnt++;
    end

  data_known: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    v_o |-> !$isunknown(data_o))
    else
    begin
      $error("response data unknown while valid");
      err_cnt++;
    end

endmodule

bind dcache_top dcache_checker checker_i
  ( .clk_i               (clk_i)
  , .rst_n_i             (rst_n_i)
  , .v_o                 (v_o)
  , .data_o              (data_o)
  , .mem_fwd_o           (mem_fwd_o)
  , .mem_fwd_data_o      (mem_fwd_data_o)
  , .mem_fwd_v_o         (mem_fwd_v_o)
  , .mem_fwd_ready_and_i (mem_fwd_ready_and_i)
  );

`default_nettype wire

/* dcache_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module dcache_tb;

  typedef struct packed {
    dcache_pkg::dcache_op_e op;
    dcache_pkg::paddr_t     paddr;
    dcache_pkg::dword_t     sdata;
    dcache_pkg::dword_t     exp;
  } row_s;

  logic                    clk_i;
  logic                    rst_n_i;
  dcache_pkg::dcache_pkt_s dcache_pkt_i;
  logic                    v_i;
  logic                    ready_o;
  dcache_pkg::dword_t      data_o;
  logic                    v_o;
  dcache_pkg::mem_hdr_s    mem_fwd_o;
  dcache_pkg::dword_t      mem_fwd_data_o;
  logic                    mem_fwd_v_o;
  logic                    mem_fwd_ready_and_i;
  dcache_pkg::mem_hdr_s    mem_rev_i;
  dcache_pkg::dword_t      mem_rev_data_i;
  logic                    mem_rev_v_i;
  logic                    mem_rev_ready_and_o;

  row_s               rows[$];
  int                 store_rows[$];
  dcache_pkg::dword_t mem [dcache_pkg::paddr_t];

  int     resp_cnt = 0;
  int     wr_cnt = 0;
  int     cycles = 0;
  int     limit = 0;
  integer seed;

  dcache_top dcache_top_i (.*);

  // Unwritten memory reads back its own address in every 16-bit field
  function automatic dcache_pkg::dword_t pattern(dcache_pkg::paddr_t a);
    return {4{a}};
  endfunction

  task automatic add_load(dcache_pkg::paddr_t a, dcache_pkg::dword_t exp);
    rows.push_back(row_s'{dcache_pkg::e_dcache_ld, a, '0, exp});
  endtask

  task automatic add_store(dcache_pkg::paddr_t a, dcache_pkg::dword_t d);
    store_rows.push_back(rows.size());
    rows.push_back(row_s'{dcache_pkg::e_dcache_sd, a, d, d});
  endtask

  task automatic check_dword(dcache_pkg::dword_t got, dcache_pkg::dword_t exp, string name);
    if (got !== exp)
    begin
      $display("mismatch at %0t: %s got %h, expected %h", $time, name, got, exp);
      $display("Regression failed");
      $fatal(1);
    end
  endtask

  task automatic check_mem_hdr(dcache_pkg::mem_hdr_s got, dcache_pkg::mem_hdr_s exp,
                               string name);
    if (got !== exp)
    begin
      $display("mismatch at %0t: %s got %h, expected %h", $time, name, got, exp);
      $display("Regression failed");
      $fatal(1);
    end
  endtask

  initial
  begin
    clk_i = 1'b0;
    forever #4 clk_i = ~clk_i;
  end

  initial
  begin : fwd_backpressure
    logic [31:0] rnd;
    seed = 32'hc9e7;
    mem_fwd_ready_and_i = 1'b0;
    forever
    begin
      @(posedge clk_i);
      #1;
      rnd = $random(seed);
      mem_fwd_ready_and_i = rnd[0];
    end
  end

  // One outstanding beat at a time, answered 3 cycles after the forward beat
  initial
  begin : memory_model
    dcache_pkg::mem_hdr_s hdr;
    dcache_pkg::mem_hdr_s exp_hdr;
    dcache_pkg::dword_t   rdata;
    row_s                 st;
    mem_rev_v_i    = 1'b0;
    mem_rev_i      = '0;
    mem_rev_data_i = '0;
    forever
    begin
      @(posedge clk_i);
      if (rst_n_i && mem_fwd_v_o && mem_fwd_ready_and_i)
      begin
        hdr   = mem_fwd_o;
        rdata = mem_fwd_data_o;
        if (hdr.op == dcache_pkg::e_mem_wr && wr_cnt >= store_rows.size())
        begin
          $display("Memory write seen at %0t with no store left in the table", $time);
          $display("Regression failed");
          $fatal(1);
        end
        else
        begin
          if (hdr.op == dcache_pkg::e_mem_wr)
          begin
            st      = rows[store_rows[wr_cnt]];
            exp_hdr = dcache_pkg::mem_hdr_s'{dcache_pkg::e_mem_wr, st.paddr};
            check_mem_hdr(hdr, exp_hdr, "mem_fwd_o");
            check_dword(rdata, st.sdata, "mem_fwd_data_o");
            mem[hdr.paddr] = rdata;
            wr_cnt++;
          end
          else
            rdata = mem.exists(hdr.paddr) ? mem[hdr.paddr] : pattern(hdr.paddr);
          repeat (3) @(posedge clk_i);
          #1;
          mem_rev_i      = hdr;
          mem_rev_data_i = rdata;
          mem_rev_v_i    = 1'b1;
          @(posedge clk_i);
          while (!mem_rev_ready_and_o)
            @(posedge clk_i);
          #1;
          mem_rev_v_i = 1'b0;
        end
      end
    end
  end

  // Responses come back in table order
  always @(posedge clk_i)
  begin
    cycles = cycles + 1;
    if (limit > 0 && cycles > limit)
    begin
      $display("Timeout after %0d cycles, %0d of %0d responses seen",
               cycles, resp_cnt, rows.size());
      $display("Regression failed");
      $fatal(1);
    end
    else if (dcache_top_i.checker_i.err_cnt != 0)
    begin
      $display("Assertion in dcache_checker failed before %0t", $time);
      $display("Regression failed");
      $fatal(1);
    end
    else if (rst_n_i && v_o && resp_cnt >= rows.size())
    begin
      $display("Response at %0t with no request left to answer", $time);
      $display("Regression failed");
      $fatal(1);
    end
    else if (rst_n_i && v_o)
    begin
      if (rows[resp_cnt].op == dcache_pkg::e_dcache_ld)
        check_dword(data_o, rows[resp_cnt].exp, "data_o");
      resp_cnt++;
    end
  end

  initial
  begin : stimulus
    rst_n_i      = 1'b0;
    v_i          = 1'b0;
    dcache_pkt_i = '0;

    add_load(16'h0100, pattern(16'h0100));
    add_load(16'h0100, pattern(16'h0100));
    add_store(16'h0108, 64'h1111_2222_3333_4444);
    add_load(16'h0108, 64'h1111_2222_3333_4444);
    add_store(16'h0100, 64'hdead_beef_0bad_f00d);
    add_load(16'h0100, 64'hdead_beef_0bad_f00d);
    // Same index as 0x0100, other tag
    add_load(16'h0180, pattern(16'h0180));
    add_load(16'h0100, 64'hdead_beef_0bad_f00d);
    add_load(16'h0180, pattern(16'h0180));
    add_load(16'h0200, pattern(16'h0200));
    add_store(16'h0210, 64'h0123_4567_89ab_cdef);
    add_load(16'h0210, 64'h0123_4567_89ab_cdef);
    add_load(16'h0218, pattern(16'h0218));
    add_store(16'h0200, 64'hfedc_ba98_7654_3210);
    add_load(16'h0200, 64'hfedc_ba98_7654_3210);
    add_load(16'h0300, pattern(16'h0300));
    add_load(16'h0208, pattern(16'h0208));
    add_load(16'h0200, 64'hfedc_ba98_7654_3210);
    add_load(16'h0108, 64'h1111_2222_3333_4444);
    add_load(16'h0380, pattern(16'h0380));
    limit = rows.size() * 40 + 100;

    repeat (2) @(posedge clk_i);
    #1;
    rst_n_i = 1'b1;

    // Back to back, so the FIFO fills and ready_o drops
    foreach (rows[i])
    begin
      dcache_pkt_i.op    = rows[i].op;
      dcache_pkt_i.paddr = rows[i].paddr;
      dcache_pkt_i.data  = rows[i].sdata;
      v_i = 1'b1;
      @(posedge clk_i);
      while (!ready_o)
        @(posedge clk_i);
      #1;
    end
    v_i = 1'b0;

    wait (resp_cnt == rows.size() && wr_cnt == store_rows.size());
    // Assertions on the last edge settle one edge later
    @(posedge clk_i);
    #1;
    if (dcache_top_i.checker_i.err_cnt != 0)
    begin
      $display("Assertion in dcache_checker failed during the run");
      $display("Regression failed");
      $fatal(1);
    end
    else
    begin
      $display("Regression passed");
      $finish;
    end
  end

endmodule

`default_nettype wire

/* compile.f */
+incdir+.
dcache_pkg.sv
replay_fifo.sv
dcache_pipe.sv
miss_engine.sv
dcache_top.sv
dcache_checker.sv
dcache_tb.sv
